//--- verilog.f
src/execPkg.sv
src/execBus.sv
src/decodeStage.sv
src/aluStage.sv
src/resultStage.sv
src/mipsExecUnit.sv
test/clockGen.sv
test/execUnit_props.sv
test/execTb.sv

//--- Makefile
TOP       ?= execTb
SEED      ?= 25301
LOG       ?= sim.log
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	-./$(OBJDIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Test passed" $(LOG) || { echo "FAIL: no pass line in $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- test/execTb.sv
`timescale 1ns/1ps
`default_nettype none

module execTb;

	logic        clk;
	logic        rstN;
	logic        inReq;
	logic [31:0] instr;
	logic [31:0] rsVal;
	logic [31:0] rtVal;
	logic        outAck;
	logic        inAck;
	logic        outReq;
	logic [31:0] result;
	logic        overflow;
	logic        trap;

	logic [31:0] stimInstr[$];
	logic [31:0] stimRs[$];
	logic [31:0] stimRt[$];
	string       stimName[$];
	logic [33:0] expQ[$]; // {result, overflow, trap} in issue order
	string       expName[$];
	int          total;

	clockGen clockGen_inst (
		.clk  (clk),
		.rstN (rstN)
	);

	mipsExecUnit mipsExecUnit_inst (
		.clk      (clk),
		.rstN     (rstN),
		.inReq    (inReq),
		.instr    (instr),
		.rsVal    (rsVal),
		.rtVal    (rtVal),
		.outAck   (outAck),
		.inAck    (inAck),
		.outReq   (outReq),
		.result   (result),
		.overflow (overflow),
		.trap     (trap)
	);

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] rWord(input logic [5:0] opc, input logic [5:0] fn,
		input logic [4:0] sh);
		return {opc, 5'd1, 5'd2, 5'd3, sh, fn}; // register numbers do not matter here
	endfunction

	function automatic logic [31:0] iWord(input logic [5:0] opc, input logic [15:0] imm);
		return {opc, 5'd1, 5'd2, imm};
	endfunction

	// length of the run of bitVal from the msb
	function automatic logic [31:0] leadingRun(input logic [31:0] word, input logic bitVal);
		int n;
		n = 0;
		while (n < 32 && word[31-n] == bitVal)
			n++;
		return 32'(n);
	endfunction

	function automatic logic [33:0] refModel(input logic [31:0] ins, input logic [31:0] rs,
		input logic [31:0] rt);
		logic [31:0] b;
		logic [31:0] r;
		logic [5:0]  fn;
		logic [4:0]  amt;
		logic        ov;
		logic        tp;
		longint      sa;
		longint      sb;
		longint      ua;
		longint      ub;
		longint      wide;
		r   = '0;
		ov  = 1'b0;
		tp  = 1'b0;
		b   = rt;
		fn  = ins[5:0];
		amt = ins[2] ? rs[4:0] : ins[10:6]; // variable shifts take rs
		if (ins[31:26] == execPkg::opcSpecial2) begin
			if (ins[5:0] == execPkg::fnClz)
				r = leadingRun(rs, 1'b0);
			else if (ins[5:0] == execPkg::fnClo)
				r = leadingRun(rs, 1'b1);
			return {r, 2'b00};
		end
		if (ins[31:26] != execPkg::opcSpecial) begin
			b = (ins[31:26] inside {execPkg::opcAndi, execPkg::opcOri, execPkg::opcXori})
				? {16'h0000, ins[15:0]} : {{16{ins[15]}}, ins[15:0]};
			case (ins[31:26])
				execPkg::opcAddi:  fn = execPkg::fnAdd;
				execPkg::opcAddiu: fn = execPkg::fnAddu;
				execPkg::opcSlti:  fn = execPkg::fnSlt;
				execPkg::opcSltiu: fn = execPkg::fnSltu;
				execPkg::opcAndi:  fn = execPkg::fnAnd;
				execPkg::opcOri:   fn = execPkg::fnOr;
				execPkg::opcXori:  fn = execPkg::fnXor;
				default:           fn = 6'h3f; // unused funct code
			endcase
		end
		sa = longint'($signed(rs));
		sb = longint'($signed(b));
		ua = longint'(rs);
		ub = longint'(b);
		case (fn)
			execPkg::fnAdd: begin
				wide = sa + sb;
				r    = wide[31:0];
				ov   = wide != longint'($signed(r)); // sum does not fit 32 bits
			end
			execPkg::fnSub: begin
				wide = sa - sb;
				r    = wide[31:0];
				ov   = wide != longint'($signed(r));
			end
			execPkg::fnAddu: r = rs + b;
			execPkg::fnSubu: r = rs - b;
			execPkg::fnAnd:  r = rs & b;
			execPkg::fnOr:   r = rs | b;
			execPkg::fnXor:  r = rs ^ b;
			execPkg::fnNor:  r = ~(rs | b);
			execPkg::fnSlt:  r = {31'b0, sa < sb};
			execPkg::fnSltu: r = {31'b0, ua < ub};
			execPkg::fnSll, execPkg::fnSllv: r = rt << amt;
			execPkg::fnSrl, execPkg::fnSrlv: r = rt >> amt;
			execPkg::fnSra, execPkg::fnSrav: begin
				wide = longint'($signed(rt)) >>> amt;
				r    = wide[31:0];
			end
			execPkg::fnTeq:  tp = rs == b;
			execPkg::fnTne:  tp = rs != b;
			execPkg::fnTge:  tp = sa >= sb;
			execPkg::fnTgeu: tp = ua >= ub;
			execPkg::fnTlt:  tp = sa < sb;
			execPkg::fnTltu: tp = ua < ub;
			default:         r = '0;
		endcase
		return {r, ov, tp};
	endfunction

	task automatic addItem(input string name, input logic [31:0] ins, input logic [31:0] rs,
		input logic [31:0] rt);
		stimName.push_back(name);
		stimInstr.push_back(ins);
		stimRs.push_back(rs);
		stimRt.push_back(rt);
	endtask

	task automatic addArith();
		logic [5:0] rOps[8];
		logic [5:0] iOps[7];
		rOps = '{execPkg::fnAdd, execPkg::fnAddu, execPkg::fnSub, execPkg::fnSubu,
			execPkg::fnAnd, execPkg::fnOr, execPkg::fnXor, execPkg::fnNor};
		iOps = '{execPkg::opcAddi, execPkg::opcAddiu, execPkg::opcSlti, execPkg::opcSltiu,
			execPkg::opcAndi, execPkg::opcOri, execPkg::opcXori};
		for (int k = 0; k < 6; k++) begin
			foreach (rOps[j])
				addItem($sformatf("arith funct %h", rOps[j]),
					rWord(execPkg::opcSpecial, rOps[j], 5'd0), $urandom(), $urandom());
			foreach (iOps[j])
				addItem($sformatf("immediate opcode %h", iOps[j]),
					iWord(iOps[j], 16'($urandom())), $urandom(), $urandom());
		end
		addItem("add overflow up", rWord(execPkg::opcSpecial, execPkg::fnAdd, 5'd0),
			32'h7fffffff, 32'h00000001);
		addItem("add overflow down", rWord(execPkg::opcSpecial, execPkg::fnAdd, 5'd0),
			32'h80000000, 32'hffffffff);
		addItem("sub overflow down", rWord(execPkg::opcSpecial, execPkg::fnSub, 5'd0),
			32'h80000000, 32'h00000001);
		addItem("sub overflow up", rWord(execPkg::opcSpecial, execPkg::fnSub, 5'd0),
			32'h7fffffff, 32'hffffffff);
		addItem("addu wraps quietly", rWord(execPkg::opcSpecial, execPkg::fnAddu, 5'd0),
			32'h7fffffff, 32'h00000001);
		addItem("subu wraps quietly", rWord(execPkg::opcSpecial, execPkg::fnSubu, 5'd0),
			32'h80000000, 32'h00000001);
		addItem("addi overflow", iWord(execPkg::opcAddi, 16'h0001), 32'h7fffffff, 32'h0);
		addItem("addi negative overflow", iWord(execPkg::opcAddi, 16'h8000), 32'h80000000, 32'h0);
		addItem("addiu wraps quietly", iWord(execPkg::opcAddiu, 16'hffff), 32'h80000000, 32'h0);
	endtask

	task automatic addShifts();
		logic [5:0] fns[6];
		logic [4:0] amts[4];
		fns  = '{execPkg::fnSll, execPkg::fnSrl, execPkg::fnSra,
			execPkg::fnSllv, execPkg::fnSrlv, execPkg::fnSrav};
		amts = '{5'd0, 5'd31, 5'd1, 5'($urandom())};
		foreach (fns[j])
			foreach (amts[k])
				for (int s = 0; s < 2; s++)
					addItem($sformatf("shift funct %h amount %0d", fns[j], amts[k]),
						rWord(execPkg::opcSpecial, fns[j], amts[k]),
						{27'($urandom()), ~amts[k]}, {s[0], 31'($urandom())});
	endtask

	task automatic addCompares();
		logic [31:0] sltW;
		logic [31:0] sltuW;
		logic [31:0] cloW;
		logic [31:0] clzW;
		sltW  = rWord(execPkg::opcSpecial, execPkg::fnSlt, 5'd0);
		sltuW = rWord(execPkg::opcSpecial, execPkg::fnSltu, 5'd0);
		cloW  = rWord(execPkg::opcSpecial2, execPkg::fnClo, 5'd0);
		clzW  = rWord(execPkg::opcSpecial2, execPkg::fnClz, 5'd0);
		addItem("slt negative vs positive", sltW, 32'hfffffff0, 32'h5);
		addItem("slt positive vs negative", sltW, 32'h5, 32'hfffffff0);
		addItem("sltu large vs small", sltuW, 32'hfffffff0, 32'h5);
		addItem("sltu small vs large", sltuW, 32'h5, 32'hfffffff0);
		addItem("slti negative imm", iWord(execPkg::opcSlti, 16'hfff0), 32'h5, 32'h0);
		addItem("sltiu negative imm", iWord(execPkg::opcSltiu, 16'hfff0), 32'h5, 32'h0);
		addItem("clo all ones", cloW, 32'hffffffff, 32'h0);
		addItem("clo all zeros", cloW, 32'h0, 32'h0);
		addItem("clz all zeros", clzW, 32'h0, 32'h0);
		addItem("clz all ones", clzW, 32'hffffffff, 32'h0);
		for (int n = 1; n < 32; n += 5) begin
			addItem($sformatf("clo run of %0d", n), cloW, ~($urandom() >> n), 32'h0);
			addItem($sformatf("clz run of %0d", n), clzW, $urandom() >> n, 32'h0);
		end
	endtask

	task automatic addTraps();
		logic [5:0]  fns[6];
		logic [31:0] lhs[5];
		logic [31:0] rhs[5];
		fns = '{execPkg::fnTeq, execPkg::fnTne, execPkg::fnTge,
			execPkg::fnTgeu, execPkg::fnTlt, execPkg::fnTltu};
		lhs = '{32'd7, 32'd3, 32'd9, 32'hfffffff0, 32'd5}; // equal, less, greater, mixed signs
		rhs = '{32'd7, 32'd9, 32'd3, 32'd5, 32'hfffffff0};
		foreach (fns[j])
			foreach (lhs[k])
				addItem($sformatf("trap funct %h case %0d", fns[j], k),
					rWord(execPkg::opcSpecial, fns[j], 5'd0), lhs[k], rhs[k]);
		addItem("undefined opcode", {6'h3f, 26'($urandom())}, $urandom(), $urandom());
		addItem("lui left out", iWord(6'h0f, 16'($urandom())), $urandom(), $urandom());
		addItem("undefined funct", rWord(execPkg::opcSpecial, 6'h01, 5'd0), 32'h1, 32'h1);
		addItem("undefined special2", rWord(execPkg::opcSpecial2, 6'h3f, 5'd0), 32'h0, 32'h0);
	endtask

	task automatic addBurst(input int count);
		logic [5:0]  rFns[22];
		logic [5:0]  iOps[7];
		logic [31:0] ins;
		rFns = '{execPkg::fnAdd, execPkg::fnAddu, execPkg::fnSub, execPkg::fnSubu,
			execPkg::fnAnd, execPkg::fnOr, execPkg::fnXor, execPkg::fnNor, execPkg::fnSlt,
			execPkg::fnSltu, execPkg::fnSll, execPkg::fnSrl, execPkg::fnSra, execPkg::fnSllv,
			execPkg::fnSrlv, execPkg::fnSrav, execPkg::fnTeq, execPkg::fnTne, execPkg::fnTge,
			execPkg::fnTgeu, execPkg::fnTlt, execPkg::fnTltu};
		iOps = '{execPkg::opcAddi, execPkg::opcAddiu, execPkg::opcSlti, execPkg::opcSltiu,
			execPkg::opcAndi, execPkg::opcOri, execPkg::opcXori};
		for (int i = 0; i < count; i++) begin
			case ($urandom_range(3, 0))
				0, 1: ins = rWord(execPkg::opcSpecial, rFns[$urandom_range(21, 0)],
					5'($urandom()));
				2: ins = iWord(iOps[$urandom_range(6, 0)], 16'($urandom()));
				default: ins = rWord(execPkg::opcSpecial2,
					($urandom_range(1, 0) == 0) ? execPkg::fnClz : execPkg::fnClo, 5'd0);
			endcase
			addItem($sformatf("burst item %0d", i), ins, $urandom(), $urandom());
		end
	endtask

	task automatic checkResult();
		logic [33:0] want;
		string       name;
		assert (expQ.size() > 0)
			else stopRun("a result arrived while no instruction was outstanding");
		want = expQ.pop_front();
		name = expName.pop_front();
		assert ({result, overflow, trap} == want)
			else stopRun($sformatf(
				"[ERROR] %s: expected result %h ovf %b trap %b, actual result %h ovf %b trap %b",
				name, want[33:2], want[1], want[0], result, overflow, trap));
	endtask

	task automatic sendAll();
		for (int i = 0; i < total; i++) begin
			instr = stimInstr[i];
			rsVal = stimRs[i];
			rtVal = stimRt[i];
			expQ.push_back(refModel(stimInstr[i], stimRs[i], stimRt[i]));
			expName.push_back(stimName[i]);
			inReq = 1'b1;
			do begin
				@(posedge clk);
				#1;
			end while (!inAck);
			inReq = 1'b0;
			do begin
				@(posedge clk);
				#1;
			end while (inAck);
		end
	endtask

	task automatic receiveAll();
		int got;
		int delay;
		got = 0;
		while (got < total) begin
			@(posedge clk);
			#1;
			if (outReq) begin
				checkResult();
				got++;
				delay = $urandom_range(5, 0); // back-pressure
				repeat (delay) begin
					@(posedge clk);
					#1;
				end
				outAck = 1'b1;
				do begin
					@(posedge clk);
					#1;
				end while (outReq);
				outAck = 1'b0;
			end
		end
	endtask

	initial begin
		void'($urandom(25301));
		inReq  = 1'b0;
		instr  = '0;
		rsVal  = '0;
		rtVal  = '0;
		outAck = 1'b0;
		addArith();
		addShifts();
		addCompares();
		addTraps();
		addBurst(200);
		total = stimInstr.size();
		wait (rstN === 1'b1);
		@(posedge clk);
		#1;
		fork
			sendAll();
			receiveAll();
		join
		repeat (10) begin
			@(posedge clk);
			#1;
			assert (!outReq) else stopRun("an extra result appeared after the last one");
		end
		$display("Test passed");
		$finish;
	end

	// 40 cycles per instruction plus reset
	initial begin
		wait (total > 0);
		repeat (40 * total + 16) @(posedge clk);
		stopRun("watchdog expired because the execute unit stopped responding");
	end

endmodule

`default_nettype wire

//--- test/execUnit_props.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit_props (
	input logic        clk,
	input logic        rstN,
	input logic        inReq,
	input logic        inAck,
	input logic        outReq,
	input logic        outAck,
	input logic [31:0] result,
	input logic        resValid,  // ALU stage holds an item
	input logic        resWaitLow // result stage waits for ack low
);

	resetQuiet: assert property (@(posedge clk) !rstN |-> !inAck && !outReq)
		else $error("inAck or outReq high during reset");

	outHold: assert property (@(posedge clk) disable iff (!rstN)
		outReq && !outAck |=> outReq && $stable(result))
		else $error("outReq dropped or result changed before outAck");

	ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
		$rose(inAck) |-> $past(inReq))
		else $error("inAck rose while inReq was low");

	// empty stages behind decode give the short path
	fastPath: assert property (@(posedge clk) disable iff (!rstN)
		$rose(inAck) && !resValid && !outReq && !resWaitLow |-> ##2 $rose(outReq))
		else $error("outReq did not rise two cycles after inAck on an empty pipe");

endmodule

bind mipsExecUnit execUnit_props execUnit_props_inst (
	.clk        (clk),
	.rstN       (rstN),
	.inReq      (inReq),
	.inAck      (inAck),
	.outReq     (outReq),
	.outAck     (outAck),
	.result     (result),
	.resValid   (resBus.valid),
	.resWaitLow (resultStage_inst.waitLow)
);

`default_nettype wire

//--- test/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	initial begin
		rstN = 1'b0;
		repeat (8) @(posedge clk);
		#1 rstN = 1'b1; // released off the edge
	end

endmodule

`default_nettype wire

//--- src/mipsExecUnit.sv
`timescale 1ns/1ps
`default_nettype none

module mipsExecUnit (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          inReq,
	input  logic [31:0]                   instr,
	input  logic [execPkg::dataWidth-1:0] rsVal,
	input  logic [execPkg::dataWidth-1:0] rtVal,
	input  logic                          outAck,
	output logic                          inAck,
	output logic                          outReq,
	output logic [execPkg::dataWidth-1:0] result,
	output logic                          overflow,
	output logic                          trap
);

	execBus opBus ();  // decode to ALU
	execBus resBus (); // ALU to result

	decodeStage decodeStage_inst (
		.clk   (clk),
		.rstN  (rstN),
		.inReq (inReq),
		.instr (instr),
		.rsVal (rsVal),
		.rtVal (rtVal),
		.inAck (inAck),
		.down  (opBus.src)
	);

	aluStage aluStage_inst (
		.clk  (clk),
		.rstN (rstN),
		.up   (opBus.dst),
		.down (resBus.src)
	);

	resultStage resultStage_inst (
		.clk      (clk),
		.rstN     (rstN),
		.outAck   (outAck),
		.up       (resBus.dst),
		.outReq   (outReq),
		.result   (result),
		.overflow (overflow),
		.trap     (trap)
	);

endmodule

`default_nettype wire

//--- src/resultStage.sv
`timescale 1ns/1ps
`default_nettype none

module resultStage (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          outAck,
	execBus.dst                           up,
	output logic                          outReq,
	output logic [execPkg::dataWidth-1:0] result,
	output logic                          overflow,
	output logic                          trap
);

	logic waitLow; // ack seen high, waiting for it to drop
	logic load;

	// outReq doubles as the occupied flag of the result register
	assign up.stall = outReq || waitLow;
	assign load     = up.valid && !up.stall;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			outReq  <= 1'b0;
			waitLow <= 1'b0;
		end else begin
			if (load) begin
				outReq <= 1'b1;
			end else if (outReq && outAck) begin
				outReq  <= 1'b0; // frees the register
				waitLow <= 1'b1;
			end else if (waitLow && !outAck) begin
				waitLow <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			result   <= up.result;
			overflow <= up.overflow;
			trap     <= up.trap;
		end
	end

endmodule

`default_nettype wire

//--- src/aluStage.sv
`timescale 1ns/1ps
`default_nettype none

module aluStage (
	input  logic clk,
	input  logic rstN,
	execBus.dst  up,
	execBus.src  down
);

	localparam int w = execPkg::dataWidth;

	logic [w-1:0] a;
	logic [w-1:0] b;
	logic [w-1:0] sum;
	logic [w-1:0] diff;
	logic         lessS;
	logic         lessU;
	logic         equal;
	logic [5:0]   cloCnt;
	logic [5:0]   clzCnt;
	logic [w-1:0] aluRes;
	logic         aluOvf;
	logic         aluTrap;
	logic         load;

	// counts zeros from the msb down, 0 to 32
	function automatic logic [5:0] leadZeros(input logic [w-1:0] word);
		logic [5:0] n;
		logic       hit;
		n   = 6'd0;
		hit = 1'b0;
		for (int i = w - 1; i >= 0; i--) begin
			if (!hit && !word[i])
				n = n + 6'd1;
			else
				hit = 1'b1;
		end
		return n;
	endfunction

	assign a      = up.opA;
	assign b      = up.opB;
	assign sum    = a + b;
	assign diff   = a - b;
	assign lessS  = $signed(a) < $signed(b);
	assign lessU  = a < b;
	assign equal  = a == b;
	assign cloCnt = leadZeros(~a); // leading ones
	assign clzCnt = leadZeros(a);

	always_comb begin
		case (up.aluOp)
			execPkg::opAdd,
			execPkg::opAddu: aluRes = sum;
			execPkg::opSub,
			execPkg::opSubu: aluRes = diff;
			execPkg::opOr:   aluRes = a | b;
			execPkg::opAnd:  aluRes = a & b;
			execPkg::opNor:  aluRes = ~(a | b);
			execPkg::opXor:  aluRes = a ^ b;
			execPkg::opSll:  aluRes = b << up.shiftAmt;
			execPkg::opSrl:  aluRes = b >> up.shiftAmt;
			execPkg::opSra:  aluRes = $signed(b) >>> up.shiftAmt; // sign fill
			execPkg::opSlt:  aluRes = {{(w-1){1'b0}}, lessS};
			execPkg::opSltu: aluRes = {{(w-1){1'b0}}, lessU};
			execPkg::opClo:  aluRes = {{(w-6){1'b0}}, cloCnt};
			execPkg::opClz:  aluRes = {{(w-6){1'b0}}, clzCnt};
			default:         aluRes = '0; // traps and nop
		endcase
	end

	// signed overflow only for the trapping add and sub
	always_comb begin
		case (up.aluOp)
			execPkg::opAdd: aluOvf = (a[w-1] == b[w-1]) && (sum[w-1] != a[w-1]);
			execPkg::opSub: aluOvf = (a[w-1] != b[w-1]) && (diff[w-1] != a[w-1]);
			default:        aluOvf = 1'b0;
		endcase
	end

	always_comb begin
		case (up.aluOp)
			execPkg::opTeq:  aluTrap = equal;
			execPkg::opTne:  aluTrap = !equal;
			execPkg::opTge:  aluTrap = !lessS;
			execPkg::opTgeu: aluTrap = !lessU;
			execPkg::opTlt:  aluTrap = lessS;
			execPkg::opTltu: aluTrap = lessU;
			default:         aluTrap = 1'b0;
		endcase
	end

	assign up.stall = down.valid && down.stall; // full and blocked
	assign load     = up.valid && !up.stall;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			down.valid <= 1'b0;
		end else if (load) begin
			down.valid <= 1'b1;
		end else if (!down.stall) begin
			down.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			down.result   <= aluRes;
			down.overflow <= aluOvf;
			down.trap     <= aluTrap;
		end
	end

	// operand fields are spent at this stage
	assign down.aluOp    = execPkg::opNop;
	assign down.opA      = '0;
	assign down.opB      = '0;
	assign down.shiftAmt = 5'd0;

endmodule

`default_nettype wire

//--- src/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          inReq,
	input  execPkg::instrWord             instr,
	input  logic [execPkg::dataWidth-1:0] rsVal,
	input  logic [execPkg::dataWidth-1:0] rtVal,
	output logic                          inAck,
	execBus.src                           down
);

	logic [execPkg::aluOpWidth-1:0] decOp;
	logic [execPkg::dataWidth-1:0]  decB;
	logic [4:0]                     decAmt;
	logic [execPkg::dataWidth-1:0]  immSext;
	logic [execPkg::dataWidth-1:0]  immZext;
	logic                           canLoad;
	logic                           take;

	assign immSext = {{16{instr.iFmt.imm16[15]}}, instr.iFmt.imm16};
	assign immZext = {16'h0000, instr.iFmt.imm16};

	always_comb begin
		decOp  = execPkg::opNop;
		decB   = rtVal;
		decAmt = 5'd0;
		case (instr.rFmt.opcode)
			execPkg::opcSpecial:
				case (instr.rFmt.funct)
					execPkg::fnAdd:  decOp = execPkg::opAdd;
					execPkg::fnAddu: decOp = execPkg::opAddu;
					execPkg::fnSub:  decOp = execPkg::opSub;
					execPkg::fnSubu: decOp = execPkg::opSubu;
					execPkg::fnAnd:  decOp = execPkg::opAnd;
					execPkg::fnOr:   decOp = execPkg::opOr;
					execPkg::fnXor:  decOp = execPkg::opXor;
					execPkg::fnNor:  decOp = execPkg::opNor;
					execPkg::fnSlt:  decOp = execPkg::opSlt;
					execPkg::fnSltu: decOp = execPkg::opSltu;
					execPkg::fnSll: begin
						decOp  = execPkg::opSll;
						decAmt = instr.rFmt.shamt;
					end
					execPkg::fnSrl: begin
						decOp  = execPkg::opSrl;
						decAmt = instr.rFmt.shamt;
					end
					execPkg::fnSra: begin
						decOp  = execPkg::opSra;
						decAmt = instr.rFmt.shamt;
					end
					execPkg::fnSllv: begin
						decOp  = execPkg::opSll;
						decAmt = rsVal[4:0]; // amount from rs
					end
					execPkg::fnSrlv: begin
						decOp  = execPkg::opSrl;
						decAmt = rsVal[4:0];
					end
					execPkg::fnSrav: begin
						decOp  = execPkg::opSra;
						decAmt = rsVal[4:0];
					end
					execPkg::fnTeq:  decOp = execPkg::opTeq;
					execPkg::fnTne:  decOp = execPkg::opTne;
					execPkg::fnTge:  decOp = execPkg::opTge;
					execPkg::fnTgeu: decOp = execPkg::opTgeu;
					execPkg::fnTlt:  decOp = execPkg::opTlt;
					execPkg::fnTltu: decOp = execPkg::opTltu;
					default:         decOp = execPkg::opNop;
				endcase
			execPkg::opcSpecial2:
				case (instr.rFmt.funct)
					execPkg::fnClz: decOp = execPkg::opClz;
					execPkg::fnClo: decOp = execPkg::opClo;
					default:        decOp = execPkg::opNop;
				endcase
			execPkg::opcAddi: begin
				decOp = execPkg::opAdd;
				decB  = immSext;
			end
			execPkg::opcAddiu: begin
				decOp = execPkg::opAddu;
				decB  = immSext;
			end
			execPkg::opcSlti: begin
				decOp = execPkg::opSlt;
				decB  = immSext;
			end
			execPkg::opcSltiu: begin
				decOp = execPkg::opSltu;
				decB  = immSext; // sign-extended, compared unsigned
			end
			execPkg::opcAndi: begin
				decOp = execPkg::opAnd;
				decB  = immZext;
			end
			execPkg::opcOri: begin
				decOp = execPkg::opOr;
				decB  = immZext;
			end
			execPkg::opcXori: begin
				decOp = execPkg::opXor;
				decB  = immZext;
			end
			default: decOp = execPkg::opNop;
		endcase
	end

	assign canLoad = !down.valid || !down.stall; // empty or draining now
	assign take    = inReq && !inAck && canLoad;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			inAck      <= 1'b0;
			down.valid <= 1'b0;
		end else begin
			if (take) begin
				inAck      <= 1'b1;
				down.valid <= 1'b1;
			end else begin
				if (!inReq)
					inAck <= 1'b0;
				if (!down.stall)
					down.valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			down.aluOp    <= decOp;
			down.opA      <= rsVal;
			down.opB      <= decB;
			down.shiftAmt <= decAmt;
		end
	end

	// result fields belong to the next hop
	assign down.result   = '0;
	assign down.overflow = 1'b0;
	assign down.trap     = 1'b0;

endmodule

`default_nettype wire

//--- src/execBus.sv
`timescale 1ns/1ps
`default_nettype none

interface execBus;

	logic valid;
	logic stall;

	// operation hop
	logic [execPkg::aluOpWidth-1:0] aluOp;
	logic [execPkg::dataWidth-1:0]  opA;
	logic [execPkg::dataWidth-1:0]  opB;
	logic [4:0]                     shiftAmt;

	// result hop
	logic [execPkg::dataWidth-1:0]  result;
	logic                           overflow;
	logic                           trap;

	modport src (
		output valid, aluOp, opA, opB, shiftAmt, result, overflow, trap,
		input  stall
	);

	modport dst (
		input  valid, aluOp, opA, opB, shiftAmt, result, overflow, trap,
		output stall
	);

endinterface

`default_nettype wire

//--- src/execPkg.sv
`default_nettype none

package execPkg;

	localparam int dataWidth  = 32;
	localparam int aluOpWidth = 5;

	// ALU operation codes
	localparam logic [aluOpWidth-1:0] opAdd  = 5'b00000;
	localparam logic [aluOpWidth-1:0] opSub  = 5'b00001;
	localparam logic [aluOpWidth-1:0] opOr   = 5'b00010;
	localparam logic [aluOpWidth-1:0] opAnd  = 5'b00011;
	localparam logic [aluOpWidth-1:0] opNor  = 5'b00100;
	localparam logic [aluOpWidth-1:0] opXor  = 5'b00101;
	localparam logic [aluOpWidth-1:0] opSll  = 5'b00110;
	localparam logic [aluOpWidth-1:0] opSrl  = 5'b00111;
	localparam logic [aluOpWidth-1:0] opSra  = 5'b01000;
	localparam logic [aluOpWidth-1:0] opSlt  = 5'b01001;
	localparam logic [aluOpWidth-1:0] opSltu = 5'b01010;
	localparam logic [aluOpWidth-1:0] opAddu = 5'b01100;
	localparam logic [aluOpWidth-1:0] opClo  = 5'b01101;
	localparam logic [aluOpWidth-1:0] opClz  = 5'b01110;
	localparam logic [aluOpWidth-1:0] opSubu = 5'b10000;
	localparam logic [aluOpWidth-1:0] opTeq  = 5'b10001;
	localparam logic [aluOpWidth-1:0] opTge  = 5'b10010; // signed
	localparam logic [aluOpWidth-1:0] opTgeu = 5'b10011;
	localparam logic [aluOpWidth-1:0] opTlt  = 5'b10100; // signed
	localparam logic [aluOpWidth-1:0] opTltu = 5'b10101;
	localparam logic [aluOpWidth-1:0] opTne  = 5'b10110;
	localparam logic [aluOpWidth-1:0] opNop  = 5'b11111;

	localparam logic [5:0] opcSpecial  = 6'h00;
	localparam logic [5:0] opcSpecial2 = 6'h1c;
	localparam logic [5:0] opcAddi     = 6'h08;
	localparam logic [5:0] opcAddiu    = 6'h09;
	localparam logic [5:0] opcSlti     = 6'h0a;
	localparam logic [5:0] opcSltiu    = 6'h0b;
	localparam logic [5:0] opcAndi     = 6'h0c;
	localparam logic [5:0] opcOri      = 6'h0d;
	localparam logic [5:0] opcXori     = 6'h0e;

	// SPECIAL funct field
	localparam logic [5:0] fnSll  = 6'h00;
	localparam logic [5:0] fnSrl  = 6'h02;
	localparam logic [5:0] fnSra  = 6'h03;
	localparam logic [5:0] fnSllv = 6'h04;
	localparam logic [5:0] fnSrlv = 6'h06;
	localparam logic [5:0] fnSrav = 6'h07;
	localparam logic [5:0] fnAdd  = 6'h20;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSub  = 6'h22;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnXor  = 6'h26;
	localparam logic [5:0] fnNor  = 6'h27;
	localparam logic [5:0] fnSlt  = 6'h2a;
	localparam logic [5:0] fnSltu = 6'h2b;
	localparam logic [5:0] fnTge  = 6'h30;
	localparam logic [5:0] fnTgeu = 6'h31;
	localparam logic [5:0] fnTlt  = 6'h32;
	localparam logic [5:0] fnTltu = 6'h33;
	localparam logic [5:0] fnTeq  = 6'h34;
	localparam logic [5:0] fnTne  = 6'h36;
	localparam logic [5:0] fnClz  = 6'h20; // SPECIAL2
	localparam logic [5:0] fnClo  = 6'h21; // SPECIAL2

	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rFmt;
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm16;
		} iFmt;
	} instrWord;

endpackage

`default_nettype wire
